//--- wbm_pkg.sv
/*
 * wbm_pkg
 * Shared widths, size codes and data types for the two-bank
 * Wishbone memory subsystem.
 */
package wbm_pkg;

  // one 8-byte word per bus beat
  localparam int data_width_c = 64;

  // one select bit per byte lane
  localparam int sel_width_c = data_width_c / 8;

  // zero bits appended to a word address to form a byte address
  localparam int byte_offset_c = 3;

  typedef logic [data_width_c-1:0] data_t;

  typedef logic [sel_width_c-1:0] sel_t;

  // log2 of the number of bytes a command moves
  typedef enum logic [1:0] {
    e_size_1 = 2'b00,
    e_size_2 = 2'b01,
    e_size_4 = 2'b10,
    e_size_8 = 2'b11
  } msg_size_e;

endpackage

//--- wb_mem_client.sv
/*
 * wb_mem_client
 * Bridges Wishbone classic cycles to uncached memory commands.
 * Decodes byte selects into a size code, replicates narrow write
 * data and turns the memory response into a Wishbone acknowledge.
 */
`timescale 1ns/1ns

module wb_mem_client #(
  parameter int adr_width_p = 4
) (
  input  logic                                        clk_i,
  input  logic                                        reset_i,

  // wishbone slave side
  input  logic [adr_width_p-1:0]                      adr_i,
  input  wbm_pkg::data_t                              dat_i,
  input  wbm_pkg::sel_t                               sel_i,
  input  logic                                        we_i,
  input  logic                                        cyc_i,
  input  logic                                        stb_i,
  output wbm_pkg::data_t                              dat_o,
  output logic                                        ack_o,

  // memory command
  output logic [adr_width_p+wbm_pkg::byte_offset_c-1:0] fwd_addr_o,
  output wbm_pkg::msg_size_e                          fwd_size_o,
  output logic                                        fwd_write_o,
  output wbm_pkg::data_t                              fwd_data_o,
  output logic                                        fwd_v_o,
  input  logic                                        fwd_ready_i,

  // memory response
  input  wbm_pkg::data_t                              rev_data_i,
  input  logic                                        rev_v_i,
  output logic                                        rev_ready_o
);

  typedef enum logic [1:0] {
    e_reset     = 2'b00,
    e_ready     = 2'b01,
    e_wait_resp = 2'b10
  } state_e;

  state_e             state_r;
  state_e             state_n;
  wbm_pkg::msg_size_e size;
  logic               req;

  assign req = cyc_i & stb_i;

  // only the exact patterns get a narrow size, everything else is a full word
  always_comb begin
    case (sel_i)
      wbm_pkg::sel_t'(8'h01): size = wbm_pkg::e_size_1;
      wbm_pkg::sel_t'(8'h03): size = wbm_pkg::e_size_2;
      wbm_pkg::sel_t'(8'h0f): size = wbm_pkg::e_size_4;
      default:                size = wbm_pkg::e_size_8;
    endcase
  end

  // copy the low bytes across the whole bus
  always_comb begin
    case (size)
      wbm_pkg::e_size_1: fwd_data_o = {8{dat_i[7:0]}};
      wbm_pkg::e_size_2: fwd_data_o = {4{dat_i[15:0]}};
      wbm_pkg::e_size_4: fwd_data_o = {2{dat_i[31:0]}};
      default:           fwd_data_o = dat_i;
    endcase
  end

  assign fwd_addr_o  = {adr_i, {wbm_pkg::byte_offset_c{1'b0}}};
  assign fwd_size_o  = size;
  assign fwd_write_o = we_i;
  assign dat_o       = rev_data_i;

  // responses are always taken
  assign rev_ready_o = 1'b1;

  always_comb begin
    state_n = state_r;
    fwd_v_o = 1'b0;
    ack_o   = 1'b0;
    case (state_r)
      e_reset: begin
        state_n = e_ready;
      end
      e_ready: begin
        fwd_v_o = req;
        if (req && fwd_ready_i) begin
          // a response already waiting completes the cycle at once
          if (rev_v_i) begin
            ack_o = 1'b1;
          end else begin
            state_n = e_wait_resp;
          end
        end
      end
      e_wait_resp: begin
        ack_o = rev_v_i;
        if (rev_v_i) begin
          state_n = e_ready;
        end
      end
      default: begin
        state_n = e_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_reset;
    end else begin
      state_r <= state_n;
    end
  end

  // master must keep the cycle open until it is acknowledged
  a_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    ack_o |-> cyc_i);

endmodule

//--- mem_bank.sv
/*
 * mem_bank
 * Single-ported word memory. Takes one command at a time, applies
 * sized writes to the low bytes of a word and answers one cycle later.
 */
`timescale 1ns/1ns

module mem_bank #(
  parameter int depth_p = 16
) (
  input  logic                                           clk_i,
  input  logic                                           reset_i,

  // command
  input  logic [wbm_pkg::byte_offset_c+$clog2(depth_p)-1:0] fwd_addr_i,
  input  wbm_pkg::msg_size_e                             fwd_size_i,
  input  logic                                           fwd_write_i,
  input  wbm_pkg::data_t                                 fwd_data_i,
  input  logic                                           fwd_v_i,
  output logic                                           fwd_ready_o,

  // response
  output wbm_pkg::data_t                                 rev_data_o,
  output logic                                           rev_v_o,
  input  logic                                           rev_ready_i
);

  localparam int idx_width_lp = $clog2(depth_p);

  wbm_pkg::data_t          mem_r [depth_p];
  wbm_pkg::data_t          wr_mask;
  wbm_pkg::data_t          wr_word;
  wbm_pkg::data_t          rev_data_r;
  logic [idx_width_lp-1:0] word_addr;
  logic [idx_width_lp-1:0] idx;
  logic                    rev_v_r;
  logic                    accept;

  // word bits of the byte address, folded onto the array depth
  assign word_addr = fwd_addr_i[wbm_pkg::byte_offset_c +: idx_width_lp];
  assign idx       = idx_width_lp'(word_addr % depth_p);

  always_comb begin
    case (fwd_size_i)
      wbm_pkg::e_size_1: wr_mask = 64'h0000_0000_0000_00ff;
      wbm_pkg::e_size_2: wr_mask = 64'h0000_0000_0000_ffff;
      wbm_pkg::e_size_4: wr_mask = 64'h0000_0000_ffff_ffff;
      default:           wr_mask = '1;
    endcase
  end

  // merged word as it will be after the write
  assign wr_word = (mem_r[idx] & ~wr_mask) | (fwd_data_i & wr_mask);

  // one outstanding response at most
  assign fwd_ready_o = ~rev_v_r;
  assign accept      = fwd_v_i & fwd_ready_o;

  always_ff @(posedge clk_i) begin
    if (accept && fwd_write_i) begin
      mem_r[idx] <= wr_word;
    end
  end

  // writes echo the updated word
  always_ff @(posedge clk_i) begin
    if (accept) begin
      rev_data_r <= fwd_write_i ? wr_word : mem_r[idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rev_v_r <= 1'b0;
    end else if (accept) begin
      rev_v_r <= 1'b1;
    end else if (rev_ready_i) begin
      rev_v_r <= 1'b0;
    end
  end

  assign rev_data_o = rev_data_r;
  assign rev_v_o    = rev_v_r;

  // the bridge never stalls a response
  a_rev_taken: assert property (@(posedge clk_i) disable iff (reset_i)
    rev_v_o |-> rev_ready_i);

endmodule

//--- wb_bank_select.sv
/*
 * wb_bank_select
 * Steers each Wishbone cycle to one of two branches by the top
 * address bit and merges the branch acknowledges and read data.
 */
`timescale 1ns/1ns

module wb_bank_select #(
  parameter int adr_width_p = 5
) (
  input  logic           clk_i,
  input  logic           reset_i,
  input  logic           adr_msb_i,
  input  logic           cyc_i,
  input  logic           stb_i,
  output logic           cyc0_o,
  output logic           stb0_o,
  output logic           cyc1_o,
  output logic           stb1_o,
  input  logic           ack0_i,
  input  logic           ack1_i,
  input  wbm_pkg::data_t dat0_i,
  input  wbm_pkg::data_t dat1_i,
  output logic           ack_o,
  output wbm_pkg::data_t dat_o
);

  // the top bit picks the bank, so at least one word bit must remain
  if (adr_width_p < 2) begin : g_width_check
    $error("address too narrow for bank selection");
  end

  logic busy_r;
  logic sel_r;
  logic bank_sel;

  // first cycle uses the live address, then the captured choice
  assign bank_sel = busy_r ? sel_r : adr_msb_i;

  assign cyc0_o = cyc_i & ~bank_sel;
  assign stb0_o = stb_i & ~bank_sel;
  assign cyc1_o = cyc_i & bank_sel;
  assign stb1_o = stb_i & bank_sel;

  assign ack_o = ack0_i | ack1_i;
  assign dat_o = bank_sel ? dat1_i : dat0_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_r <= 1'b0;
    end else if (ack_o || !cyc_i) begin
      busy_r <= 1'b0;
    end else if (stb_i) begin
      busy_r <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!busy_r && cyc_i && stb_i) begin
      sel_r <= adr_msb_i;
    end
  end

  // only one branch ever owns the cycle
  a_one_ack: assert property (@(posedge clk_i) disable iff (reset_i)
    !(ack0_i && ack1_i));

endmodule

//--- wb_mem_subsystem.sv
/*
 * wb_mem_subsystem
 * Wishbone slave with two memory banks, each behind its own
 * command bridge, chosen by the top word-address bit.
 */
`timescale 1ns/1ns

module wb_mem_subsystem #(
  parameter int adr_width_p = 5,
  parameter int depth_p     = 16
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic [adr_width_p-1:0] adr_i,
  input  wbm_pkg::data_t         dat_i,
  input  wbm_pkg::sel_t          sel_i,
  input  logic                   we_i,
  input  logic                   cyc_i,
  input  logic                   stb_i,
  output wbm_pkg::data_t         dat_o,
  output logic                   ack_o
);

  // bank address drops the select bit
  localparam int branch_adr_width_lp = adr_width_p - 1;
  localparam int fwd_adr_width_lp    = branch_adr_width_lp + wbm_pkg::byte_offset_c;
  localparam int bank_adr_width_lp   = wbm_pkg::byte_offset_c + $clog2(depth_p);

  logic                        cyc [2];
  logic                        stb [2];
  logic                        ack [2];
  wbm_pkg::data_t              dat [2];
  logic [fwd_adr_width_lp-1:0] fwd_addr [2];
  wbm_pkg::msg_size_e          fwd_size [2];
  logic                        fwd_write [2];
  wbm_pkg::data_t              fwd_data [2];
  logic                        fwd_v [2];
  logic                        fwd_ready [2];
  wbm_pkg::data_t              rev_data [2];
  logic                        rev_v [2];
  logic                        rev_ready [2];

  wb_bank_select #(
    .adr_width_p(adr_width_p)
  ) wb_bank_select_i (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .adr_msb_i (adr_i[adr_width_p-1]),
    .cyc_i     (cyc_i),
    .stb_i     (stb_i),
    .cyc0_o    (cyc[0]),
    .stb0_o    (stb[0]),
    .cyc1_o    (cyc[1]),
    .stb1_o    (stb[1]),
    .ack0_i    (ack[0]),
    .ack1_i    (ack[1]),
    .dat0_i    (dat[0]),
    .dat1_i    (dat[1]),
    .ack_o     (ack_o),
    .dat_o     (dat_o)
  );

  for (genvar b = 0; b < 2; b++) begin : g_branch
    wb_mem_client #(
      .adr_width_p(branch_adr_width_lp)
    ) wb_mem_client_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .adr_i       (adr_i[branch_adr_width_lp-1:0]),
      .dat_i       (dat_i),
      .sel_i       (sel_i),
      .we_i        (we_i),
      .cyc_i       (cyc[b]),
      .stb_i       (stb[b]),
      .dat_o       (dat[b]),
      .ack_o       (ack[b]),
      .fwd_addr_o  (fwd_addr[b]),
      .fwd_size_o  (fwd_size[b]),
      .fwd_write_o (fwd_write[b]),
      .fwd_data_o  (fwd_data[b]),
      .fwd_v_o     (fwd_v[b]),
      .fwd_ready_i (fwd_ready[b]),
      .rev_data_i  (rev_data[b]),
      .rev_v_i     (rev_v[b]),
      .rev_ready_o (rev_ready[b])
    );

    mem_bank #(
      .depth_p(depth_p)
    ) mem_bank_i (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .fwd_addr_i  (fwd_addr[b][bank_adr_width_lp-1:0]),
      .fwd_size_i  (fwd_size[b]),
      .fwd_write_i (fwd_write[b]),
      .fwd_data_i  (fwd_data[b]),
      .fwd_v_i     (fwd_v[b]),
      .fwd_ready_o (fwd_ready[b]),
      .rev_data_o  (rev_data[b]),
      .rev_v_o     (rev_v[b]),
      .rev_ready_i (rev_ready[b])
    );
  end

endmodule

//--- tb_wb_mem_subsystem.sv
/*
 * tb_wb_mem_subsystem
 * Random-stimulus testbench for the two-bank Wishbone memory.
 * Checks read data against a word model and counts acknowledges.
 */
`timescale 1ns/1ns

module tb_wb_mem_subsystem;

  localparam int adr_width_lp    = 5;
  localparam int depth_lp        = 16;
  localparam int num_words_lp    = 32;
  localparam int num_random_lp   = 400;
  // fill, read back, bank independence, sel patterns
  localparam int num_directed_lp = 2 * num_words_lp + 2 * 16 + 8 * 4 * 2;
  localparam int timeout_lp      = (num_directed_lp + num_random_lp) * 4 + 100;

  logic                    clk_i;
  logic                    reset_i;
  logic [adr_width_lp-1:0] adr_i;
  wbm_pkg::data_t          dat_i;
  wbm_pkg::sel_t           sel_i;
  logic                    we_i;
  logic                    cyc_i;
  logic                    stb_i;
  wbm_pkg::data_t          dat_o;
  logic                    ack_o;

  wbm_pkg::data_t model_mem [num_words_lp];
  wbm_pkg::sel_t  sel_list [8] = '{8'h01, 8'h03, 8'h0f, 8'hff, 8'h05, 8'h80, 8'hf0, 8'h3c};
  int             error_count;
  int             req_count;
  int             ack_count;
  int             cycle_count;

  wb_mem_subsystem #(
    .adr_width_p(adr_width_lp),
    .depth_p    (depth_lp)
  ) wb_mem_subsystem_i (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .adr_i  (adr_i),
    .dat_i  (dat_i),
    .sel_i  (sel_i),
    .we_i   (we_i),
    .cyc_i  (cyc_i),
    .stb_i  (stb_i),
    .dat_o  (dat_o),
    .ack_o  (ack_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  task automatic check_value(input string name, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      error_count++;
      $display("Error %s: expected %h, actual %h", name, exp_val, act_val);
    end
  endtask

  // low 1, 2 or 4 bytes for the exact patterns, whole word otherwise
  function automatic void model_write(input logic [adr_width_lp-1:0] adr,
                                      input wbm_pkg::data_t dat, input wbm_pkg::sel_t sel);
    wbm_pkg::data_t mask;
    case (sel)
      8'h01:   mask = 64'h0000_0000_0000_00ff;
      8'h03:   mask = 64'h0000_0000_0000_ffff;
      8'h0f:   mask = 64'h0000_0000_ffff_ffff;
      default: mask = '1;
    endcase
    model_mem[adr] = (model_mem[adr] & ~mask) | (dat & mask);
  endfunction

  // one classic cycle, held until acknowledged
  task automatic run_cycle(input string name, input logic we, input logic [adr_width_lp-1:0] adr,
                           input wbm_pkg::data_t dat, input wbm_pkg::sel_t sel);
    int wait_cycles;
    wait_cycles = 0;
    @(posedge clk_i);
    adr_i <= adr;
    dat_i <= dat;
    sel_i <= sel;
    we_i  <= we;
    cyc_i <= 1'b1;
    stb_i <= 1'b1;
    req_count++;
    do begin
      @(negedge clk_i);
      wait_cycles++;
    end while (!ack_o);
    // strobe cycle plus the ack cycle
    check_value({name, " latency"}, 64'd2, 64'(wait_cycles));
    if (we) begin
      model_write(adr, dat, sel);
      // write responses carry the word as stored
      check_value({name, " echo"}, model_mem[adr], dat_o);
    end else begin
      check_value(name, model_mem[adr], dat_o);
    end
    @(posedge clk_i);
    cyc_i <= 1'b0;
    stb_i <= 1'b0;
  endtask

  // every acknowledge must answer a live strobe
  always @(negedge clk_i) begin
    if (!reset_i && ack_o) begin
      ack_count++;
      if (!stb_i) begin
        error_count++;
        $display("acknowledge seen while no strobe was presented");
      end
    end
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= timeout_lp) begin
      $display("timeout after %0d cycles, a request was never acknowledged", cycle_count);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    logic                    we;
    logic [adr_width_lp-1:0] adr;
    logic [2:0]              kind;
    wbm_pkg::data_t          data;
    error_count = 0;
    req_count   = 0;
    ack_count   = 0;
    cycle_count = 0;
    reset_i     = 1'b1;
    adr_i       = '0;
    dat_i       = '0;
    sel_i       = '0;
    we_i        = 1'b0;
    cyc_i       = 1'b0;
    stb_i       = 1'b0;
    void'($urandom(32'hb6ea));
    repeat (2) @(posedge clk_i);
    reset_i <= 1'b0;

    // quiet bus after reset
    repeat (4) begin
      @(negedge clk_i);
      check_value("idle ack", 64'd0, 64'(ack_o));
    end

    // full words everywhere, distinct per address
    for (int a = 0; a < num_words_lp; a++) begin
      run_cycle("fill", 1'b1, adr_width_lp'(a), {$urandom(), $urandom()}, 8'hff);
    end
    for (int a = 0; a < num_words_lp; a++) begin
      run_cycle("full read", 1'b0, adr_width_lp'(a), '0, 8'hff);
    end

    // low half changes must not reach the upper bank
    for (int a = 0; a < 16; a++) begin
      run_cycle("bank write", 1'b1, adr_width_lp'(a), {$urandom(), $urandom()}, 8'hff);
      run_cycle("bank other", 1'b0, adr_width_lp'(a + 16), '0, 8'hff);
    end

    // narrow and odd sel patterns, four spread addresses each
    for (int s = 0; s < 8; s++) begin
      for (int k = 0; k < 4; k++) begin
        adr = adr_width_lp'((k * 9 + s * 3) % num_words_lp);
        run_cycle("sel write", 1'b1, adr, {$urandom(), $urandom()}, sel_list[s]);
        run_cycle("sel read", 1'b0, adr, '0, 8'hff);
      end
    end

    for (int i = 0; i < num_random_lp; i++) begin
      we   = 1'($urandom_range(0, 1));
      adr  = adr_width_lp'($urandom_range(0, num_words_lp - 1));
      data = {$urandom(), $urandom()};
      kind = 3'($urandom_range(0, 7));
      run_cycle("random", we, adr, data, sel_list[kind]);
      repeat ($urandom_range(0, 1)) @(posedge clk_i);
    end

    @(negedge clk_i);
    check_value("ack count", 64'(req_count), 64'(ack_count));
    $display("errors: %0d, requests: %0d, acks: %0d", error_count, req_count, ack_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- vlog.f
wbm_pkg.sv
wb_mem_client.sv
mem_bank.sv
wb_bank_select.sv
wb_mem_subsystem.sv
tb_wb_mem_subsystem.sv

//--- run_sim.sh
#!/bin/sh
# builds the two-bank Wishbone memory testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f vlog.f \
  --top-module tb_wb_mem_subsystem -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Simulation failed" sim.log; then
  exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
  echo "simulation ended without a result line"
  exit 1
fi

exit 0
